// ==== logic/uartPkg.sv ====
////////////////////////////////////////////////////////////
// shared types for the serial port subsystem
// widths, FSM state encodings and the status flags word
// imported by every RTL block and by the testbench
////////////////////////////////////////////////////////////

`default_nettype none

package uartPkg;

	// frame format, fixed at one byte per character
	localparam int dataBits = 8;

	////////////////////////////////////////////////////////////
	// vector types
	////////////////////////////////////////////////////////////

	typedef logic [dataBits-1:0] uartByte_t;	// one serial character
	typedef logic [3:0] tickCount_t;	// 16x oversampling ticks within a bit
	typedef logic [2:0] bitIndex_t;	// data bit position 0..7

	////////////////////////////////////////////////////////////
	// FSM states
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		rxIdle,
		rxStart,
		rxData,
		rxStop
	} rxState_t;

	typedef enum logic [1:0] {
		txIdle,
		txStart,
		txData,
		txStop
	} txState_t;

	// processor-visible flags, one per FIFO edge condition
	typedef struct packed {
		logic rxEmpty;	// nothing to read
		logic rxFull;	// further frames get dropped
		logic txEmpty;	// transmitter has nothing queued
		logic txFull;	// further writes get dropped
	} uartStatus_t;

endpackage

`default_nettype wire

// ==== logic/baudTickGen.sv ====
////////////////////////////////////////////////////////////
// oversampling strobe generator
// one-cycle sTick every clkPerTick clocks, 16 ticks per bit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module baudTickGen #(
	parameter int clkPerTick = 4
) (
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	// keep at least one bit even for a divide by one
	localparam int cntWidth = (clkPerTick > 1) ? $clog2(clkPerTick) : 1;
	localparam logic [cntWidth-1:0] reloadVal = cntWidth'(clkPerTick - 1);

	logic [cntWidth-1:0] cntReg;	// free running down counter

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cntReg <= reloadVal;
			sTick <= 1'b0;
		end
		else if (cntReg == '0)
		begin
			cntReg <= reloadVal;	// wrap and fire
			sTick <= 1'b1;
		end
		else
		begin
			cntReg <= cntReg - 1'b1;
			sTick <= 1'b0;	// strobe is a single cycle
		end
	end

endmodule

`default_nettype wire

// ==== logic/uartRec.sv ====
////////////////////////////////////////////////////////////
// serial receiver, 16x oversampled, 8 data bits LSB first
// samples each bit at its middle, pulses rxDoneTick with
// the byte valid on rxByte at the end of the stop bit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartRec #(
	parameter int stopTicks = 16	// 16 ticks is one stop bit
) (
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	input  logic rx,
	output logic rxDoneTick,
	output uartPkg::uartByte_t rxByte
);

	import uartPkg::*;

	rxState_t stateReg, stateNext;
	tickCount_t sReg, sNext;	// ticks within current bit
	bitIndex_t nReg, nNext;	// data bits received so far
	uartByte_t bReg, bNext;	// shift register, fills from the top

	////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= rxIdle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;	// data only, qualified by rxDoneTick
	end

	////////////////////////////////////////////////////////////
	// next state logic
	////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;

		case (stateReg)
			rxIdle:
				if (!rx)	// falling edge, start bit begins
				begin
					stateNext = rxStart;
					sNext = '0;
				end
			rxStart:
				if (sTick)
				begin
					if (sReg == tickCount_t'(7))	// middle of start bit
					begin
						sNext = '0;
						nNext = '0;
						// line back high here means a glitch, not a frame
						stateNext = rx ? rxIdle : rxData;
					end
					else
						sNext = sReg + tickCount_t'(1);
				end
			rxData:
				if (sTick)
				begin
					if (sReg == tickCount_t'(15))	// middle of next data bit
					begin
						sNext = '0;
						bNext = {rx, bReg[dataBits-1:1]};	// LSB arrives first
						if (nReg == bitIndex_t'(dataBits - 1))
							stateNext = rxStop;
						else
							nNext = nReg + bitIndex_t'(1);
					end
					else
						sNext = sReg + tickCount_t'(1);
				end
			rxStop:
				if (sTick)
				begin
					if (sReg == tickCount_t'(stopTicks - 1))
					begin
						stateNext = rxIdle;
						rxDoneTick = 1'b1;	// byte complete
					end
					else
						sNext = sReg + tickCount_t'(1);
				end
			default:
				stateNext = rxIdle;
		endcase
	end

	assign rxByte = bReg;

endmodule

`default_nettype wire

// ==== logic/uartTrans.sv ====
////////////////////////////////////////////////////////////
// serial transmitter, same frame as the receiver
// takes a byte from idle when txValid is high, pulses
// txTaken, then sends start, 8 bits LSB first, stop
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartTrans #(
	parameter int stopTicks = 16
) (
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	input  logic txValid,
	input  uartPkg::uartByte_t txByte,
	output logic txTaken,
	output logic tx
);

	import uartPkg::*;

	txState_t stateReg, stateNext;
	tickCount_t sReg, sNext;	// ticks spent in current bit
	bitIndex_t nReg, nNext;	// data bits sent
	uartByte_t bReg, bNext;	// shifts right, bit 0 is on the line
	logic txReg, txNext;	// registered line, no glitches

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= txIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	////////////////////////////////////////////////////////////
	// next state logic, line level set on each transition
	////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txTaken = 1'b0;

		case (stateReg)
			txIdle:
			begin
				txNext = 1'b1;
				if (txValid)
				begin
					txTaken = 1'b1;	// pops the tx FIFO head
					bNext = txByte;
					sNext = '0;
					txNext = 1'b0;	// start bit
					stateNext = txStart;
				end
			end
			txStart:
				if (sTick)
				begin
					if (sReg == tickCount_t'(15))
					begin
						sNext = '0;
						nNext = '0;
						txNext = bReg[0];	// first data bit
						stateNext = txData;
					end
					else
						sNext = sReg + tickCount_t'(1);
				end
			txData:
				if (sTick)
				begin
					if (sReg == tickCount_t'(15))
					begin
						sNext = '0;
						bNext = {1'b0, bReg[dataBits-1:1]};
						if (nReg == bitIndex_t'(dataBits - 1))
						begin
							txNext = 1'b1;	// stop bit
							stateNext = txStop;
						end
						else
						begin
							txNext = bReg[1];	// next bit after the shift
							nNext = nReg + bitIndex_t'(1);
						end
					end
					else
						sNext = sReg + tickCount_t'(1);
				end
			txStop:
				if (sTick)
				begin
					if (sReg == tickCount_t'(stopTicks - 1))
						stateNext = txIdle;	// ready for the next byte
					else
						sNext = sReg + tickCount_t'(1);
				end
			default:
				stateNext = txIdle;
		endcase
	end

	assign tx = txReg;

endmodule

`default_nettype wire

// ==== logic/uartFifo.sv ====
////////////////////////////////////////////////////////////
// first-word-fall-through byte FIFO, 2**fifoAddrWidth deep
// head byte sits on rdData whenever empty is low
// writes when full and reads when empty are dropped
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartFifo #(
	parameter int fifoAddrWidth = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic wrEn,
	input  logic rdEn,
	input  uartPkg::uartByte_t wrData,
	output uartPkg::uartByte_t rdData,
	output logic empty,
	output logic full
);

	import uartPkg::*;

	localparam int depth = 1 << fifoAddrWidth;

	uartByte_t mem [depth];

	// one extra bit tells a full lap from an empty one
	logic [fifoAddrWidth:0] wrPtr;
	logic [fifoAddrWidth:0] rdPtr;
	logic wrOk;
	logic rdOk;

	assign wrOk = wrEn && !full;
	assign rdOk = rdEn && !empty;

	////////////////////////////////////////////////////////////
	// pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (wrOk)
				wrPtr <= wrPtr + 1'b1;
			if (rdOk)
				rdPtr <= rdPtr + 1'b1;	// head moves on next edge
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (wrOk)
			mem[wrPtr[fifoAddrWidth-1:0]] <= wrData;
	end

	////////////////////////////////////////////////////////////
	// flags and head
	////////////////////////////////////////////////////////////

	assign empty = (wrPtr == rdPtr);
	assign full = (wrPtr[fifoAddrWidth] != rdPtr[fifoAddrWidth]) &&
		(wrPtr[fifoAddrWidth-1:0] == rdPtr[fifoAddrWidth-1:0]);	// same slot, other lap

	assign rdData = mem[rdPtr[fifoAddrWidth-1:0]];	// fall through, no read latency

endmodule

`default_nettype wire

// ==== logic/uartCore.sv ====
////////////////////////////////////////////////////////////
// serial port top, tick generator, receiver, transmitter
// and one FIFO per direction
// processor side uses wrStrobe/rdStrobe and the status word
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartCore #(
	parameter int clkPerTick = 4,	// 64 clocks per bit at default
	parameter int stopTicks = 16,
	parameter int fifoAddrWidth = 4	// 16 entries each way
) (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	input  logic wrStrobe,
	input  logic rdStrobe,
	input  uartPkg::uartByte_t wrData,
	output uartPkg::uartByte_t rdData,
	output logic tx,
	output uartPkg::uartStatus_t status
);

	import uartPkg::*;

	logic sTick;	// shared 16x timebase
	logic rxDoneTick;
	uartByte_t rxByte;
	logic rxEmpty, rxFull;
	logic txEmpty, txFull;
	logic txValid, txTaken;
	uartByte_t txByte;

	////////////////////////////////////////////////////////////
	// timebase
	////////////////////////////////////////////////////////////

	baudTickGen #(.clkPerTick(clkPerTick)) tickGen0 (
		.clk(clk),
		.reset(reset),
		.sTick(sTick)
	);

	////////////////////////////////////////////////////////////
	// receive path, line -> FSM -> FIFO -> processor
	////////////////////////////////////////////////////////////

	uartRec #(.stopTicks(stopTicks)) rec0 (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.rx(rx),
		.rxDoneTick(rxDoneTick),
		.rxByte(rxByte)
	);

	uartFifo #(.fifoAddrWidth(fifoAddrWidth)) rxFifo (
		.clk(clk),
		.reset(reset),
		.wrEn(rxDoneTick),	// one push per frame
		.rdEn(rdStrobe),
		.wrData(rxByte),
		.rdData(rdData),
		.empty(rxEmpty),
		.full(rxFull)
	);

	////////////////////////////////////////////////////////////
	// transmit path, processor -> FIFO -> FSM -> line
	////////////////////////////////////////////////////////////

	uartFifo #(.fifoAddrWidth(fifoAddrWidth)) txFifo (
		.clk(clk),
		.reset(reset),
		.wrEn(wrStrobe),
		.rdEn(txTaken),	// popped when the FSM latches the head
		.wrData(wrData),
		.rdData(txByte),
		.empty(txEmpty),
		.full(txFull)
	);

	assign txValid = !txEmpty;

	uartTrans #(.stopTicks(stopTicks)) trans0 (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.txValid(txValid),
		.txByte(txByte),
		.txTaken(txTaken),
		.tx(tx)
	);

	// status word straight from the FIFO flags
	assign status = '{rxEmpty: rxEmpty, rxFull: rxFull, txEmpty: txEmpty, txFull: txFull};

endmodule

`default_nettype wire

// ==== bench/uartChecker.sv ====
////////////////////////////////////////////////////////////
// scoreboard for the serial port testbench
// models both FIFOs, rebuilds frames seen on tx, compares
// rdData, status and tx against reference functions
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartChecker #(
	parameter int fifoDepth = 16,
	parameter int bitCycles = 64	// clocks per serial bit
) (
	input  logic clk,
	input  logic reset,
	input  logic tx,
	input  logic wrStrobe,
	input  logic rdStrobe,
	input  uartPkg::uartByte_t wrData,
	input  uartPkg::uartByte_t rdData,
	input  uartPkg::uartStatus_t status,
	input  logic frameDone,	// bench finished a frame on rx
	input  uartPkg::uartByte_t frameByte,
	input  logic flagCheck,	// compare status this cycle
	output int passCount,
	output int failCount,
	output int txPending
);

	import uartPkg::*;

	uartByte_t rxQ [$];	// what the rx FIFO should hold
	uartByte_t txQ [$];	// bytes still due on tx, in order
	int txCount;	// tx FIFO occupancy model
	logic txPrev;
	logic inFrame;
	int frameCyc;	// clocks since start edge seen
	int bitsSeen;
	logic [9:0] gotFrame;	// fills from the top, start ends in bit 0

	// line level at frame position pos, 0 is start, 9 is stop
	function automatic logic expFrameBit(input uartByte_t b, input int pos);
		uartByte_t sh;
		sh = b >> (pos - 1);
		if (pos == 0)
			return 1'b0;
		else if (pos == 9)
			return 1'b1;
		return sh[0];
	endfunction

	function automatic uartStatus_t expFlags(input int rxCnt, input int txCnt);
		uartStatus_t f;
		f.rxEmpty = (rxCnt == 0);
		f.rxFull = (rxCnt == fifoDepth);
		f.txEmpty = (txCnt == 0);
		f.txFull = (txCnt == fifoDepth);
		return f;
	endfunction

	task automatic compareValue(input string name, input logic [15:0] expV,
		input logic [15:0] gotV);
		if (expV === gotV)
			passCount++;
		else
		begin
			failCount++;
			$display("Fail %s: expected %h got %h at %0t", name, expV, gotV, $time);
		end
	endtask

	task automatic finishFrame();
		logic [9:0] expFrame;
		expFrame = '0;
		if (txQ.size() == 0)
		begin
			failCount++;
			$display("a frame came out on tx with nothing queued, at %0t", $time);
		end
		else
		begin
			for (int p = 0; p < 10; p++)
				expFrame = {expFrameBit(txQ[0], p), expFrame[9:1]};
			compareValue("tx", {6'h00, expFrame}, {6'h00, gotFrame});
			void'(txQ.pop_front());
		end
	endtask

	////////////////////////////////////////////////////////////
	// one pass per edge, sees values from before the edge
	////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (reset)
		begin
			rxQ.delete();
			txQ.delete();
			txCount = 0;
			txPrev = 1'b1;	// line idles high
			inFrame = 1'b0;
			frameCyc = 0;
			bitsSeen = 0;
			passCount = 0;
			failCount = 0;
		end
		else
		begin
			// start edge first, the FIFO popped on the previous edge
			if (!inFrame && txPrev && !tx)
			begin
				inFrame = 1'b1;
				frameCyc = 0;
				bitsSeen = 0;
				if (txCount > 0)
					txCount--;
			end
			else if (inFrame)
				frameCyc++;
			if (inFrame && (frameCyc % bitCycles) == bitCycles / 2)	// mid-bit
			begin
				gotFrame = {tx, gotFrame[9:1]};
				bitsSeen++;
				if (bitsSeen == 10)
				begin
					finishFrame();
					inFrame = 1'b0;	// rest of stop bit stays high
				end
			end
			txPrev = tx;
			if (wrStrobe && txCount < fifoDepth)	// full drops the write
			begin
				txQ.push_back(wrData);
				txCount++;
			end
			if (frameDone && rxQ.size() < fifoDepth)
				rxQ.push_back(frameByte);
			if (rdStrobe && rxQ.size() > 0)	// empty read is ignored
				compareValue("rdData", {8'h00, rxQ.pop_front()}, {8'h00, rdData});
			if (flagCheck)
			begin
				compareValue("status", {12'h000, expFlags(rxQ.size(), txCount)},
					{12'h000, status});
				if (txQ.size() == 0 && !inFrame)
					compareValue("tx", 16'h0001, {15'h0000, tx});	// idle level
			end
		end
		txPending = txQ.size();
	end

endmodule

`default_nettype wire

// ==== bench/uartCoreTb.sv ====
////////////////////////////////////////////////////////////
// testbench for the serial port top
// sends LFSR frames on rx, drives processor strobes, and
// leaves all comparing to the checker instance
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartCoreTb;

	import uartPkg::*;

	localparam int clkPerTick = 4;
	localparam int stopTicks = 16;
	localparam int fifoAddrWidth = 4;
	localparam int fifoDepth = 1 << fifoAddrWidth;
	localparam int bitCycles = 16 * clkPerTick;
	localparam int totalFrames = 8 + 8 + 18 + 17;	// rx and tx frames over all tests
	localparam int limitCycles = totalFrames * 10 * bitCycles + 10000;

	logic clk;
	logic reset;
	logic rxLine;
	logic wrStrobe;
	logic rdStrobe;
	uartByte_t wrData;
	uartByte_t rdData;
	logic tx;
	uartStatus_t status;
	logic frameDone;
	logic flagCheck;
	uartByte_t frameByte;
	int passCount;
	int failCount;
	int txPending;
	logic [7:0] lfsrState;
	int failsAtStart;	// error count when the current test began

	always #4 clk = ~clk;

	uartCore #(
		.clkPerTick(clkPerTick),
		.stopTicks(stopTicks),
		.fifoAddrWidth(fifoAddrWidth)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.rx(rxLine),
		.wrStrobe(wrStrobe),
		.rdStrobe(rdStrobe),
		.wrData(wrData),
		.rdData(rdData),
		.tx(tx),
		.status(status)
	);

	uartChecker #(.fifoDepth(fifoDepth), .bitCycles(bitCycles)) chk0 (
		.clk(clk),
		.reset(reset),
		.tx(tx),
		.wrStrobe(wrStrobe),
		.rdStrobe(rdStrobe),
		.wrData(wrData),
		.rdData(rdData),
		.status(status),
		.frameDone(frameDone),
		.frameByte(frameByte),
		.flagCheck(flagCheck),
		.passCount(passCount),
		.failCount(failCount),
		.txPending(txPending)
	);

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsrStep(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic nextRandByte(output uartByte_t b);
		b = '0;
		for (int i = 0; i < 8; i++)
		begin
			lfsrState = lfsrStep(lfsrState);	// one step per bit
			b = {b[6:0], lfsrState[0]};
		end
	endtask

	task automatic sendFrame(input uartByte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};	// stop, data, start
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			rxLine <= frame[0];
			frame = frame >> 1;
			repeat (bitCycles - 1) @(posedge clk);
		end
		@(posedge clk);
		frameDone <= 1'b1;	// tells the checker what went out
		frameByte <= b;
		@(posedge clk);
		frameDone <= 1'b0;
	endtask

	task automatic writeByte(input uartByte_t b);
		@(posedge clk);
		wrStrobe <= 1'b1;
		wrData <= b;
		@(posedge clk);
		wrStrobe <= 1'b0;
	endtask

	task automatic readByte();
		@(posedge clk);
		rdStrobe <= 1'b1;
		@(posedge clk);
		rdStrobe <= 1'b0;
	endtask

	task automatic checkFlags();
		@(posedge clk);
		flagCheck <= 1'b1;
		@(posedge clk);
		flagCheck <= 1'b0;
	endtask

	task automatic waitTxDrain();
		@(negedge clk);
		while (txPending != 0)
			@(negedge clk);	// watchdog covers a stuck line
	endtask

	task automatic endTest(input int num, input string name);
		@(negedge clk);
		$display("test %0d %s: %0d errors", num, name, failCount - failsAtStart);
		failsAtStart = failCount;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		uartByte_t b;
		clk = 1'b0;
		reset = 1'b1;
		rxLine = 1'b1;
		wrStrobe = 1'b0;
		rdStrobe = 1'b0;
		wrData = '0;
		frameDone = 1'b0;
		frameByte = '0;
		flagCheck = 1'b0;
		lfsrState = 8'd13;
		failsAtStart = 0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		checkFlags();
		endTest(1, "after reset");

		repeat (8)
		begin
			nextRandByte(b);
			sendFrame(b);
		end
		checkFlags();
		repeat (8) readByte();
		checkFlags();
		endTest(2, "receive path");

		repeat (8)
		begin
			nextRandByte(b);
			writeByte(b);
		end
		waitTxDrain();
		checkFlags();
		endTest(3, "transmit path");

		repeat (18)
		begin
			nextRandByte(b);
			sendFrame(b);
			checkFlags();	// rxFull from the 16th on
		end
		repeat (fifoDepth) readByte();
		checkFlags();
		endTest(4, "receive overflow");

		checkFlags();
		readByte();	// rx FIFO empty here
		checkFlags();
		repeat (20)
		begin
			nextRandByte(b);
			writeByte(b);
		end
		checkFlags();
		waitTxDrain();
		checkFlags();
		endTest(5, "transmit overflow and empty read");

		$display("checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// watchdog, sized from the frame count of all tests
	initial
	begin
		repeat (limitCycles) @(posedge clk);
		$display("timeout, the tests did not finish within %0d cycles", limitCycles);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== uartCore.f ====
logic/uartPkg.sv
logic/baudTickGen.sv
logic/uartRec.sv
logic/uartTrans.sv
logic/uartFifo.sv
logic/uartCore.sv
bench/uartChecker.sv
bench/uartCoreTb.sv

// ==== Makefile ====
# Verilator build and run for the serial port testbench

TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = uartCoreTb
FILELIST = uartCore.f
OBJDIR   = obj_dir

.PHONY: compile run clean

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJDIR)
